/* led_pkg.sv */
`default_nettype none

package led_pkg;

    // uart bit timing
    localparam int clks_per_bit = 16;                      // clk_in cycles per serial bit
    localparam int baud_bits = $clog2(clks_per_bit);

    // panel geometry
    localparam int panel_rows = 32;
    localparam int panel_cols = 64;
    localparam int row_bits = 5;
    localparam int pix_bits = $clog2(panel_cols);          // pixel index within a line

    // frame buffer
    localparam int line_bytes = 128;                       // two bytes per pixel
    localparam int col_bits = $clog2(line_bytes);
    localparam int ram_addr_bits = 12;
    localparam int ram_data_bits = 8;

    // binary-coded modulation
    localparam int num_planes = 6;
    localparam int plane_bits = $clog2(num_planes);
    localparam int plane_base_cycles = 4;                  // oe cycles of plane 0
    localparam int oe_bits = $clog2(plane_base_cycles) + num_planes;

    // single-character commands
    localparam logic [7:0] cmd_red_on = "R";
    localparam logic [7:0] cmd_red_off = "r";
    localparam logic [7:0] cmd_green_on = "G";
    localparam logic [7:0] cmd_green_off = "g";
    localparam logic [7:0] cmd_blue_on = "B";
    localparam logic [7:0] cmd_blue_off = "b";
    localparam logic [7:0] cmd_plane_first = "1";          // toggles the top plane
    localparam logic [7:0] cmd_plane_last = "6";           // toggles plane 0
    localparam logic [7:0] cmd_planes_off = "0";
    localparam logic [7:0] cmd_planes_on = "9";
    localparam logic [7:0] cmd_line = "L";                 // row byte and line data follow

endpackage

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_busy
);
    import led_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [baud_bits-1:0] tick_cnt;
    logic [2:0]           bit_cnt;
    logic                 bit_end;
    logic                 start_mid;

    // edge detection costs one cycle, so the start check comes one tick early
    assign start_mid = (tick_cnt == baud_bits'(clks_per_bit / 2 - 2));
    assign bit_end = (tick_cnt == baud_bits'(clks_per_bit - 1));
    assign rx_busy = (state != st_idle);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;                               // idle line is high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            tick_cnt <= '0;
            bit_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    tick_cnt <= '0;
                    if (!rx_sync) begin
                        state <= st_start;                 // falling start edge
                    end
                end
                st_start: begin
                    if (start_mid) begin
                        tick_cnt <= '0;
                        bit_cnt <= '0;
                        state <= rx_sync ? st_idle : st_data;  // glitch, not a start bit
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        state <= st_idle;
                        rx_valid <= rx_sync;               // framing error drops the byte
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lsb arrives first and shifts down from the top
    always_ff @(posedge clk_in) begin
        if (state == st_data && bit_end) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

endmodule

`default_nettype wire

/* led_cmd_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module led_cmd_ctrl (
    input  logic                               clk_in,
    input  logic                               reset,
    input  logic [7:0]                         rx_data,
    input  logic                               rx_valid,
    output logic [2:0]                         rgb_enable,
    output logic [led_pkg::num_planes-1:0]     brightness_enable,
    output logic                               wr_en,
    output logic [led_pkg::ram_addr_bits-1:0]  wr_addr,
    output logic [led_pkg::ram_data_bits-1:0]  wr_data,
    output logic [7:0]                         lines_loaded
);
    import led_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_row_wait,
        st_line_data
    } cmd_state_t;

    cmd_state_t            state;
    logic [row_bits-1:0]   line_row;
    logic [col_bits-1:0]   col_cnt;
    logic [plane_bits-1:0] plane_sel;
    logic                  is_plane_digit;

    // digit 1 maps to the top plane, digit 6 to plane 0
    assign plane_sel = plane_bits'(cmd_plane_last - rx_data);
    assign is_plane_digit = (rx_data >= cmd_plane_first) && (rx_data <= cmd_plane_last);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            rgb_enable <= '1;
            brightness_enable <= '1;
            lines_loaded <= '0;
            wr_en <= 1'b0;
            line_row <= '0;
            col_cnt <= '0;
        end else begin
            wr_en <= rx_valid && (state == st_line_data);  // one strobe per data byte
            if (rx_valid) begin
                case (state)
                    st_idle: begin
                        case (rx_data)
                            cmd_red_on:     rgb_enable[0] <= 1'b1;
                            cmd_red_off:    rgb_enable[0] <= 1'b0;
                            cmd_green_on:   rgb_enable[1] <= 1'b1;
                            cmd_green_off:  rgb_enable[1] <= 1'b0;
                            cmd_blue_on:    rgb_enable[2] <= 1'b1;
                            cmd_blue_off:   rgb_enable[2] <= 1'b0;
                            cmd_planes_off: brightness_enable <= '0;
                            cmd_planes_on:  brightness_enable <= '1;
                            cmd_line:       state <= st_row_wait;
                            default: begin
                                if (is_plane_digit) begin
                                    brightness_enable[plane_sel] <= ~brightness_enable[plane_sel];
                                end
                            end
                        endcase
                    end
                    st_row_wait: begin
                        if (rx_data != cmd_line) begin     // repeated L is skipped
                            line_row <= rx_data[row_bits-1:0];
                            col_cnt <= col_bits'(line_bytes - 1);
                            state <= st_line_data;
                        end
                    end
                    st_line_data: begin
                        if (col_cnt == '0) begin
                            state <= st_idle;
                            lines_loaded <= lines_loaded + 1'b1;
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // counter runs down from 127 so the first byte is pixel 0, high byte
    always_ff @(posedge clk_in) begin
        if (rx_valid && state == st_line_data) begin
            wr_addr <= {line_row, ~col_cnt[col_bits-1:1], col_cnt[0]};
            wr_data <= rx_data;
        end
    end

endmodule

`default_nettype wire

/* frame_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_ram (
    input  logic                               clk_in,
    input  logic                               wr_en,
    input  logic [led_pkg::ram_addr_bits-1:0]  wr_addr,
    input  logic [led_pkg::ram_data_bits-1:0]  wr_data,
    input  logic [led_pkg::ram_addr_bits-1:0]  rd_addr,
    output logic [led_pkg::ram_data_bits-1:0]  rd_data
);
    import led_pkg::*;

    logic [ram_data_bits-1:0] mem [0:(1 << ram_addr_bits) - 1];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data follows the address by one cycle
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* panel_scan.sv */
`timescale 1ns/100ps
`default_nettype none

module panel_scan (
    input  logic                               clk_in,
    input  logic                               reset,
    input  logic [2:0]                         rgb_enable,
    input  logic [led_pkg::num_planes-1:0]     brightness_enable,
    output logic [led_pkg::ram_addr_bits-1:0]  rd_addr,
    input  logic [led_pkg::ram_data_bits-1:0]  rd_data,
    output logic                               panel_r,
    output logic                               panel_g,
    output logic                               panel_b,
    output logic                               panel_shift,
    output logic                               panel_latch,
    output logic                               panel_oe,
    output logic [led_pkg::row_bits-1:0]       panel_row
);
    import led_pkg::*;

    typedef enum logic [1:0] {
        st_fetch,
        st_drain,
        st_latch,
        st_display
    } scan_state_t;

    scan_state_t                state;
    logic [row_bits-1:0]        row_cnt;
    logic [plane_bits-1:0]      plane_cnt;
    logic [pix_bits:0]          fetch_idx;             // pixel index and byte phase
    logic [pix_bits-1:0]        shift_cnt;
    logic [oe_bits-1:0]         oe_cnt;
    logic                       rd_pend;
    logic                       rd_pend_lo;
    logic [ram_data_bits-1:0]   hi_byte;
    logic [2*ram_data_bits-1:0] pixel_word;
    logic [num_planes-1:0]      red_ext;
    logic [num_planes-1:0]      green;
    logic [num_planes-1:0]      blue_ext;
    logic                       plane_on;
    logic                       pixel_done;
    logic                       last_shift;

    // high byte is read first in each pair
    assign rd_addr = {row_cnt, fetch_idx[pix_bits:1], ~fetch_idx[0]};
    assign panel_row = row_cnt;

    // 5-6-5 pixel, red and blue lag green by one plane and are 0 on plane 0
    assign pixel_word = {hi_byte, rd_data};
    assign red_ext = {pixel_word[15:11], 1'b0};
    assign green = pixel_word[10:5];
    assign blue_ext = {pixel_word[4:0], 1'b0};

    assign plane_on = brightness_enable[plane_cnt];
    assign pixel_done = rd_pend && rd_pend_lo;             // low byte on rd_data now
    assign last_shift = panel_shift && (shift_cnt == pix_bits'(panel_cols - 1));

    always_ff @(posedge clk_in) begin
        if (rd_pend && !rd_pend_lo) begin
            hi_byte <= rd_data;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rd_pend <= 1'b0;
            rd_pend_lo <= 1'b0;
            panel_shift <= 1'b0;
            panel_r <= 1'b0;
            panel_g <= 1'b0;
            panel_b <= 1'b0;
            shift_cnt <= '0;
        end else begin
            rd_pend <= (state == st_fetch);
            rd_pend_lo <= fetch_idx[0];
            panel_shift <= pixel_done;
            panel_r <= pixel_done && red_ext[plane_cnt] && rgb_enable[0] && plane_on;
            panel_g <= pixel_done && green[plane_cnt] && rgb_enable[1] && plane_on;
            panel_b <= pixel_done && blue_ext[plane_cnt] && rgb_enable[2] && plane_on;
            if (panel_shift) begin
                shift_cnt <= shift_cnt + 1'b1;             // wraps after the 64th pixel
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
            row_cnt <= '0;
            plane_cnt <= plane_bits'(num_planes - 1);
            fetch_idx <= '0;
            oe_cnt <= '0;
            panel_latch <= 1'b0;
            panel_oe <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    fetch_idx <= fetch_idx + 1'b1;
                    if (fetch_idx == '1) begin
                        state <= st_drain;                 // last read issued
                    end
                end
                st_drain: begin
                    if (last_shift) begin
                        panel_latch <= 1'b1;
                        state <= st_latch;
                    end
                end
                st_latch: begin
                    panel_latch <= 1'b0;
                    panel_oe <= 1'b1;
                    oe_cnt <= oe_bits'((plane_base_cycles << plane_cnt) - 1);
                    state <= st_display;
                end
                st_display: begin
                    if (oe_cnt == '0) begin
                        panel_oe <= 1'b0;
                        state <= st_fetch;
                        if (plane_cnt == '0) begin
                            // next row once the last plane goes dark
                            plane_cnt <= plane_bits'(num_planes - 1);
                            if (row_cnt == row_bits'(panel_rows - 1)) begin
                                row_cnt <= '0;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                            end
                        end else begin
                            plane_cnt <= plane_cnt - 1'b1;
                        end
                    end else begin
                        oe_cnt <= oe_cnt - 1'b1;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

endmodule

`default_nettype wire

/* led_panel_top.sv */
`timescale 1ns/100ps
`default_nettype none

module led_panel_top (
    input  logic                            clk_in,
    input  logic                            reset,
    input  logic                            uart_rx,
    output logic                            panel_r,
    output logic                            panel_g,
    output logic                            panel_b,
    output logic                            panel_shift,
    output logic                            panel_latch,
    output logic                            panel_oe,
    output logic [led_pkg::row_bits-1:0]    panel_row,
    output logic [2:0]                      rgb_enable,
    output logic [led_pkg::num_planes-1:0]  brightness_enable,
    output logic [7:0]                      lines_loaded,
    output logic                            rx_busy
);
    import led_pkg::*;

    logic [7:0]               rx_data;
    logic                     rx_valid;
    logic                     wr_en;
    logic [ram_addr_bits-1:0] wr_addr;
    logic [ram_data_bits-1:0] wr_data;
    logic [ram_addr_bits-1:0] rd_addr;
    logic [ram_data_bits-1:0] rd_data;

    uart_rx uart_rx0 (
        .clk_in   (clk_in),
        .reset    (reset),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_busy  (rx_busy)
    );

    led_cmd_ctrl cmd_ctrl0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .lines_loaded      (lines_loaded)
    );

    frame_ram frame_ram0 (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    panel_scan panel_scan0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .panel_r           (panel_r),
        .panel_g           (panel_g),
        .panel_b           (panel_b),
        .panel_shift       (panel_shift),
        .panel_latch       (panel_latch),
        .panel_oe          (panel_oe),
        .panel_row         (panel_row)
    );

endmodule

`default_nettype wire

/* led_panel_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module led_panel_asserts (
    input logic                         clk_in,
    input logic                         reset,
    input logic                         wr_en,
    input logic                         panel_oe,
    input logic                         panel_latch,
    input logic [led_pkg::row_bits-1:0] panel_row
);
    int wr_fails = 0;
    int row_fails = 0;
    int latch_fails = 0;

    // one write per received byte, a byte lasts a whole serial frame
    wr_single: assert property (@(posedge clk_in) disable iff (reset) wr_en |=> !wr_en)
        else begin
            $error("frame buffer write strobe high on two cycles in a row");
            wr_fails++;
        end

    row_stable: assert property (@(posedge clk_in) disable iff (reset)
                                 (panel_oe && $past(panel_oe)) |-> (panel_row == $past(panel_row)))
        else begin
            $error("panel_row changed while panel_oe was high");
            row_fails++;
        end

    latch_dark: assert property (@(posedge clk_in) disable iff (reset) !(panel_latch && panel_oe))
        else begin
            $error("panel_latch and panel_oe high together");
            latch_fails++;
        end

endmodule

bind led_panel_top led_panel_asserts asserts0 (
    .clk_in      (clk_in),
    .reset       (reset),
    .wr_en       (wr_en),
    .panel_oe    (panel_oe),
    .panel_latch (panel_latch),
    .panel_row   (panel_row)
);

`default_nettype wire

/* tb_led_panel.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_led_panel;
    import led_pkg::*;

    localparam int total_bytes = 409;                      // serial bytes sent over all tests
    localparam int row_checks = 4;                         // row scans compared with the model
    localparam int row_cycles = num_planes * (2 * panel_cols + 8)
                                + plane_base_cycles * ((1 << num_planes) - 1);
    localparam longint frame_cycles = longint'(panel_rows) * row_cycles;
    localparam longint timeout_cycles = longint'(total_bytes) * 10 * clks_per_bit
                                        + (row_checks + 2) * frame_cycles + 5000;

    logic                  clk_in;
    logic                  reset;
    logic                  uart_line;
    logic                  panel_r;
    logic                  panel_g;
    logic                  panel_b;
    logic                  panel_shift;
    logic                  panel_latch;
    logic                  panel_oe;
    logic [row_bits-1:0]   panel_row;
    logic [2:0]            rgb_enable;
    logic [num_planes-1:0] brightness_enable;
    logic [7:0]            lines_loaded;
    logic                  rx_busy;

    // reference model of the written lines and the enables
    logic [15:0]           model_pix [0:panel_rows-1][0:panel_cols-1];
    logic [2:0]            model_rgb;
    logic [num_planes-1:0] model_bright;
    logic [7:0]            model_lines;
    int                    errors = 0;
    int                    checks = 0;
    int                    total_errors;

    // panel monitor state
    logic [panel_cols-1:0] mon_r;
    logic [panel_cols-1:0] mon_g;
    logic [panel_cols-1:0] mon_b;
    logic [pix_bits:0]     mon_idx;
    logic [panel_cols-1:0] cap_r;
    logic [panel_cols-1:0] cap_g;
    logic [panel_cols-1:0] cap_b;
    logic [row_bits-1:0]   cap_row;
    int                    cap_plane;
    int                    cap_seq;
    int                    latch_cnt;
    int                    oe_len;
    int                    mon_errors = 0;

    led_panel_top dut0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .uart_rx           (uart_line),
        .panel_r           (panel_r),
        .panel_g           (panel_g),
        .panel_b           (panel_b),
        .panel_shift       (panel_shift),
        .panel_latch       (panel_latch),
        .panel_oe          (panel_oe),
        .panel_row         (panel_row),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .lines_loaded      (lines_loaded),
        .rx_busy           (rx_busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // collects the shifted bits of each plane and takes the plane number from the latch count
    always @(posedge clk_in) begin
        if (reset) begin
            mon_idx <= '0;
            latch_cnt <= 0;
            cap_seq <= 0;
            oe_len <= 0;
        end else begin
            if (panel_shift) begin
                mon_r[mon_idx[pix_bits-1:0]] <= panel_r;
                mon_g[mon_idx[pix_bits-1:0]] <= panel_g;
                mon_b[mon_idx[pix_bits-1:0]] <= panel_b;
                mon_idx <= mon_idx + 1'b1;
            end
            if (panel_latch) begin
                if (mon_idx != (pix_bits + 1)'(panel_cols)) begin
                    mon_errors <= mon_errors + 1;
                    $display("plane latched after %0d shifts instead of %0d",
                             mon_idx, panel_cols);
                end
                cap_r <= mon_r;
                cap_g <= mon_g;
                cap_b <= mon_b;
                cap_row <= panel_row;
                cap_plane <= num_planes - 1 - latch_cnt % num_planes;
                latch_cnt <= latch_cnt + 1;
                cap_seq <= cap_seq + 1;
                mon_idx <= '0;
            end
            // lit time of each plane doubles with the plane number
            if (panel_oe) begin
                oe_len <= oe_len + 1;
            end else if (oe_len != 0) begin
                if (oe_len != (plane_base_cycles << cap_plane)) begin
                    mon_errors <= mon_errors + 1;
                    $display("panel_oe lit for %0d cycles on plane %0d instead of %0d",
                             oe_len, cap_plane, plane_base_cycles << cap_plane);
                end
                oe_len <= 0;
            end
        end
    end

    initial begin
        #(timeout_cycles * 100);
        $display("timeout, the tests did not finish within %0d clock cycles", timeout_cycles);
        $display("Something failed");
        $finish;
    end

    task automatic check_enables(input string name, input logic [2:0] exp_rgb,
                                 input logic [num_planes-1:0] exp_bright,
                                 input logic [2:0] act_rgb,
                                 input logic [num_planes-1:0] act_bright);
        checks++;
        if (act_rgb !== exp_rgb || act_bright !== exp_bright) begin
            errors++;
            $display("ERROR %s: expected rgb %b planes %b, actual rgb %b planes %b",
                     name, exp_rgb, exp_bright, act_rgb, act_bright);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected lines %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pixel_bits(input string name, input logic [2:0] exp,
                                    input logic [2:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected bgr %b, actual %b", name, exp, act);
        end
    endtask

    // plane p takes green bit p and bit p-1 of red and blue, which stay dark on plane 0
    function automatic logic [2:0] expected_bits(input logic [row_bits-1:0] row,
                                                 input logic [plane_bits-1:0] plane,
                                                 input logic [pix_bits-1:0] pix);
        logic [15:0]           w;
        logic [4:0]            red5;
        logic [5:0]            green6;
        logic [4:0]            blue5;
        logic [plane_bits-1:0] below;
        logic                  r_bit;
        logic                  b_bit;
        logic                  lit;
        w = model_pix[row][pix];
        red5 = w[15:11];
        green6 = w[10:5];
        blue5 = w[4:0];
        if (plane == '0) begin
            r_bit = 1'b0;
            b_bit = 1'b0;
        end else begin
            below = plane - 1'b1;
            r_bit = red5[below];
            b_bit = blue5[below];
        end
        lit = model_bright[plane];
        return {b_bit & model_rgb[2] & lit,
                green6[plane] & model_rgb[1] & lit,
                r_bit & model_rgb[0] & lit};
    endfunction

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};                       // stop, data lsb first, start
        repeat (10) begin
            uart_line <= frame[0];
            frame = frame >> 1;
            repeat (clks_per_bit) @(posedge clk_in);
        end
    endtask

    task automatic wait_rx_idle();
        int n;
        n = 0;
        while (rx_busy && n < 4 * clks_per_bit) begin
            @(posedge clk_in);
            n++;
        end
        if (rx_busy) begin
            errors++;
            $display("receiver still busy long after the stop bit");
        end
        @(posedge clk_in);
    endtask

    task automatic send_cmd(input logic [7:0] cmd);
        logic [plane_bits-1:0] pl;
        case (cmd)
            "R": model_rgb[0] = 1'b1;
            "r": model_rgb[0] = 1'b0;
            "G": model_rgb[1] = 1'b1;
            "g": model_rgb[1] = 1'b0;
            "B": model_rgb[2] = 1'b1;
            "b": model_rgb[2] = 1'b0;
            "0": model_bright = '0;
            "9": model_bright = '1;
            default: begin
                if (cmd >= "1" && cmd <= "6") begin
                    pl = plane_bits'(num_planes - int'(cmd - "0"));  // digit 1 is the top plane
                    model_bright[pl] = ~model_bright[pl];
                end
            end
        endcase
        send_byte(cmd);
        wait_rx_idle();
    endtask

    task automatic load_line(input string name, input logic [7:0] row_byte);
        logic [7:0]          value;
        logic [row_bits-1:0] row;
        logic [pix_bits-1:0] pix;
        int                  i;
        int                  n;
        row = row_byte[row_bits-1:0];
        send_byte(cmd_line);
        send_byte(row_byte);
        for (i = 0; i < line_bytes; i++) begin
            value = 8'($urandom());
            pix = pix_bits'(i / 2);
            if (i % 2 == 0) begin
                model_pix[row][pix][15:8] = value;         // high byte first
            end else begin
                model_pix[row][pix][7:0] = value;
            end
            send_byte(value);
        end
        model_lines = model_lines + 8'd1;
        n = 0;
        while (lines_loaded !== model_lines && n < 4 * clks_per_bit) begin
            @(posedge clk_in);
            n++;
        end
        check_count(name, model_lines, lines_loaded);
    endtask

    // waits for a fresh scan of the row and compares all six planes
    task automatic check_row(input string name, input logic [row_bits-1:0] row);
        int                    seq;
        int                    p;
        logic [pix_bits:0]     x;
        logic [plane_bits-1:0] pl;
        while (panel_row == row) @(posedge clk_in);
        while (panel_row != row) @(posedge clk_in);
        seq = cap_seq;
        for (p = num_planes - 1; p >= 0; p--) begin
            while (cap_seq == seq) @(posedge clk_in);
            seq = cap_seq;
            pl = plane_bits'(p);
            if (cap_row != row || cap_plane != p) begin
                errors++;
                $display("ERROR %s: expected row %0d plane %0d, actual row %0d plane %0d",
                         name, row, p, cap_row, cap_plane);
            end
            for (x = '0; x < (pix_bits + 1)'(panel_cols); x++) begin
                check_pixel_bits($sformatf("%s row %0d plane %0d pixel %0d", name, row, p, x),
                                 expected_bits(row, pl, x[pix_bits-1:0]),
                                 {cap_b[x[pix_bits-1:0]], cap_g[x[pix_bits-1:0]],
                                  cap_r[x[pix_bits-1:0]]});
            end
        end
    endtask

    task automatic test_reset();
        check_enables("reset", 3'b111, '1, rgb_enable, brightness_enable);
        check_count("reset", 8'd0, lines_loaded);
        checks++;
        if (panel_oe || panel_latch) begin
            errors++;
            $display("reset: panel_oe or panel_latch high right after reset");
        end
    endtask

    task automatic test_colour();
        string cmds;
        int    i;
        cmds = "rgBGbRx";                                  // x is not a command
        for (i = 0; i < cmds.len(); i++) begin
            send_cmd(cmds[i]);
            check_enables("colour", model_rgb, model_bright, rgb_enable, brightness_enable);
        end
    endtask

    task automatic test_planes();
        string cmds;
        int    i;
        cmds = "33609";
        for (i = 0; i < cmds.len(); i++) begin
            send_cmd(cmds[i]);
            check_enables("planes", model_rgb, model_bright, rgb_enable, brightness_enable);
        end
    endtask

    task automatic test_line_load();
        send_cmd("B");                                     // all three colours lit
        check_enables("line load", model_rgb, model_bright, rgb_enable, brightness_enable);
        load_line("line load", 8'hE5);                     // upper bits are dropped to give row 5
        check_row("line load", 5'd5);
    endtask

    task automatic test_masking();
        send_cmd("r");
        send_cmd("2");                                     // plane 4 off
        check_enables("masking", model_rgb, model_bright, rgb_enable, brightness_enable);
        check_row("masking", 5'd5);
        send_cmd("R");
        send_cmd("2");
        check_enables("masking", model_rgb, model_bright, rgb_enable, brightness_enable);
    endtask

    task automatic test_back_to_back();
        logic [7:0] start;
        start = model_lines;
        load_line("back to back", 8'h6A);                  // row 10
        send_cmd("g");
        load_line("back to back", 8'hB3);                  // row 19
        check_count("back to back", start + 8'd2, lines_loaded);
        check_row("back to back", 5'd10);
        check_row("back to back", 5'd19);
        send_cmd("G");
    endtask

    initial begin
        void'($urandom(32'h48f21d5e));
        reset <= 1'b1;
        uart_line <= 1'b1;                                 // idle line
        model_rgb = 3'b111;
        model_bright = '1;
        model_lines = 8'd0;
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;
        @(posedge clk_in);
        test_reset();
        test_colour();
        test_planes();
        test_line_load();
        test_masking();
        test_back_to_back();
        total_errors = errors + mon_errors + dut0.asserts0.wr_fails
                       + dut0.asserts0.row_fails + dut0.asserts0.latch_fails;
        $display("errors: %0d, checks: %0d", total_errors, checks);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
led_pkg.sv
uart_rx.sv
led_cmd_ctrl.sv
frame_ram.sv
panel_scan.sv
led_panel_top.sv
led_panel_asserts.sv
tb_led_panel.sv

/* Makefile */
TOP = tb_led_panel

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | awk '{ print } /^Everything OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
